// File: hw/mem_geom_pkg.sv
package mem_geom_pkg;

  // the storage geometry. The bank count must stay a power of two, because the bank
  // index is taken straight from the low address bits.
  localparam int NUM_BANKS = 4;
  localparam int NUM_ROWS = 16;
  localparam int DATA_W = 16;

  localparam int BANK_W = $clog2(NUM_BANKS);
  localparam int ROW_W = $clog2(NUM_ROWS);
  localparam int ADDR_W = BANK_W + ROW_W;

  // cycles from an accepted read to rvalid.
  localparam int READ_LATENCY = 2;

  typedef logic [BANK_W-1:0] bank_t;
  typedef logic [ROW_W-1:0] row_t;
  typedef logic [ADDR_W-1:0] vaddr_t;
  typedef logic [DATA_W-1:0] word_t;

  // this records which bank's copy of a row is held in the cache row memory.
  typedef struct packed {
    logic  valid;
    bank_t owner;
  } map_entry_t;

  // these are the per-request steering controls from row_map to bank_store.
  typedef struct packed {
    logic  bank_we;
    logic  cache_we;
    logic  wb_en;
    bank_t wb_owner;
    logic  rd_cache;
  } route_t;

  function automatic bank_t addr_bank(vaddr_t addr);
    return addr[BANK_W-1:0];
  endfunction

  function automatic row_t addr_row(vaddr_t addr);
    return addr[ADDR_W-1:BANK_W];
  endfunction

endpackage

// File: hw/ctrl_pkg.sv
package ctrl_pkg;

  import mem_geom_pkg::*;

  // width of the refresh interval register and of the config data bus.
  localparam int INTERVAL_W = 16;
  localparam int CFG_DATA_W = 16;

  // refresh interval loaded at reset, in clock cycles.
  localparam int RESET_INTERVAL = 64;

  typedef enum logic [1:0] {
    OP_NONE,
    OP_READ,
    OP_WRITE
  } op_e;

  typedef struct packed {
    op_e    op;
    vaddr_t vaddr;
    word_t  wdata;
  } mem_req_t;

  typedef enum logic [0:0] {
    REG_INTERVAL,
    REG_ENABLE
  } cfg_reg_e;

  typedef struct packed {
    logic                  valid;
    logic                  write;
    cfg_reg_e              register;
    logic [CFG_DATA_W-1:0] data;
  } cfg_req_t;

  // RS_PENDING means a refresh is due but is held off by a read to its bank.
  typedef enum logic {
    RS_COUNT,
    RS_PENDING
  } refr_state_e;

endpackage

// File: hw/refresh_cfg.sv
module refresh_cfg
  import ctrl_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  input  cfg_req_t              cfg,
  output logic [CFG_DATA_W-1:0] cfg_rdata,
  output logic [INTERVAL_W-1:0] interval,
  output logic                  enable
);

  logic cfg_wr;
  logic cfg_rd;

  assign cfg_wr = cfg.valid && cfg.write;
  assign cfg_rd = cfg.valid && !cfg.write;

  // both registers take a write at the edge that accepts it.
  always_ff @(posedge clk) begin
    if (rst) begin
      interval <= INTERVAL_W'(RESET_INTERVAL);
      enable <= 1'b0;
    end else if (cfg_wr) begin
      case (cfg.register)
        REG_INTERVAL: interval <= cfg.data;
        REG_ENABLE: enable <= cfg.data[0];
        default: ;
      endcase
    end
  end

  // read-back is registered, so data shows one cycle after the read strobe.
  always_ff @(posedge clk) begin
    if (cfg_rd) begin
      case (cfg.register)
        REG_INTERVAL: cfg_rdata <= interval;
        REG_ENABLE: cfg_rdata <= {{(CFG_DATA_W-1){1'b0}}, enable};
        default: cfg_rdata <= '0;
      endcase
    end
  end

endmodule

// File: hw/refresh_sched.sv
module refresh_sched
  import mem_geom_pkg::*;
  import ctrl_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  input  logic [INTERVAL_W-1:0] interval,
  input  logic                  enable,
  input  mem_req_t              req,
  output logic                  refr_active,
  output bank_t                 refr_bank
);

  refr_state_e           state;
  logic [INTERVAL_W-1:0] cnt;
  bank_t                 next_bank;
  logic                  run;
  logic                  cnt_hit;
  logic                  conflict;
  logic                  due;

  // a zero interval counts as disabled.
  assign run = enable && (interval != '0);

  // the >= keeps the timer sane when the interval is lowered mid-count.
  assign cnt_hit = cnt >= (interval - INTERVAL_W'(1));

  // a read to the bank we want to refresh holds the refresh off this cycle.
  assign conflict = (req.op == OP_READ) && (addr_bank(req.vaddr) == next_bank);

  assign due = (state == RS_PENDING) || ((state == RS_COUNT) && run && cnt_hit);

  assign refr_active = due && !conflict;
  assign refr_bank = next_bank;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= RS_COUNT;
      cnt <= '0;
      next_bank <= '0;
    end else begin
      case (state)
        RS_COUNT: begin
          if (!run) begin
            cnt <= '0;
          end else if (cnt_hit) begin
            cnt <= '0;
            if (conflict) begin
              state <= RS_PENDING;
            end else begin
              next_bank <= next_bank + 1'b1;
            end
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        RS_PENDING: begin
          // the counter stays at zero until the postponed refresh completes.
          if (!conflict) begin
            state <= RS_COUNT;
            next_bank <= next_bank + 1'b1;
          end
        end
        default: state <= RS_COUNT;
      endcase
    end
  end

endmodule

// File: hw/row_map.sv
module row_map
  import mem_geom_pkg::*;
  import ctrl_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  mem_req_t req,
  input  logic     refr_active,
  input  bank_t    refr_bank,
  output route_t   route
);

  // one entry per row, telling which bank (if any) currently lives in the cache row.
  map_entry_t map_q [NUM_ROWS];

  bank_t      req_bank;
  row_t       req_row;
  map_entry_t entry;
  logic       owner_hit;
  logic       to_cache;

  assign req_bank = addr_bank(req.vaddr);
  assign req_row = addr_row(req.vaddr);
  assign entry = map_q[req_row];

  // the cache holds the live copy of this word.
  assign owner_hit = entry.valid && (entry.owner == req_bank);

  // the target bank is busy refreshing, so a write has to land in the cache.
  assign to_cache = refr_active && (refr_bank == req_bank);

  always_comb begin
    route = '0;
    route.wb_owner = entry.owner;
    case (req.op)
      OP_WRITE: begin
        if (to_cache) begin
          route.cache_we = 1'b1;
          // another bank's word is parked here. Flush it home before overwriting.
          if (entry.valid && (entry.owner != req_bank)) begin
            route.wb_en = 1'b1;
          end
        end else begin
          route.bank_we = 1'b1;
        end
      end
      OP_READ: begin
        route.rd_cache = owner_hit;
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < NUM_ROWS; i++) begin
        map_q[i] <= '0;
      end
    end else if (req.op == OP_WRITE) begin
      if (route.cache_we) begin
        map_q[req_row].valid <= 1'b1;
        map_q[req_row].owner <= req_bank;
      end else if (owner_hit) begin
        // the bank now holds the newest data, so the cached copy is stale.
        map_q[req_row].valid <= 1'b0;
      end
    end
  end

endmodule

// File: hw/bank_store.sv
module bank_store
  import mem_geom_pkg::*;
  import ctrl_pkg::*;
(
  input  logic     clk,
  input  mem_req_t req,
  input  route_t   route,
  output word_t    rdata,
  output logic     rvalid,
  input  logic     rst
);

  // single-ported banks plus one cache word per row.
  word_t bank_mem [NUM_BANKS][NUM_ROWS];
  word_t cache_mem [NUM_ROWS];

  bank_t req_bank;
  row_t  req_row;

  // stage one holds the read address and source.
  logic  rd_q;
  bank_t rd_bank_q;
  row_t  rd_row_q;
  logic  rd_cache_q;

  assign req_bank = addr_bank(req.vaddr);
  assign req_row = addr_row(req.vaddr);

  // a writeback always goes to a bank other than the refreshing one, and it reads the
  // cache word before this edge overwrites it.
  always_ff @(posedge clk) begin
    if (route.bank_we) begin
      bank_mem[req_bank][req_row] <= req.wdata;
    end
    if (route.cache_we) begin
      cache_mem[req_row] <= req.wdata;
    end
    if (route.wb_en) begin
      bank_mem[route.wb_owner][req_row] <= cache_mem[req_row];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_q <= 1'b0;
    end else begin
      rd_q <= (req.op == OP_READ);
    end
  end

  always_ff @(posedge clk) begin
    rd_bank_q <= req_bank;
    rd_row_q <= req_row;
    rd_cache_q <= route.rd_cache;
  end

  // stage two reads the selected array and raises rvalid.
  always_ff @(posedge clk) begin
    if (rst) begin
      rvalid <= 1'b0;
    end else begin
      rvalid <= rd_q;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_q) begin
      rdata <= rd_cache_q ? cache_mem[rd_row_q] : bank_mem[rd_bank_q][rd_row_q];
    end
  end

endmodule

// File: hw/edram_top.sv
module edram_top
  import mem_geom_pkg::*;
  import ctrl_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  input  mem_req_t              req,
  input  cfg_req_t              cfg,
  output word_t                 rdata,
  output logic                  rvalid,
  output logic [CFG_DATA_W-1:0] cfg_rdata,
  output logic                  refr_active,
  output bank_t                 refr_bank
);

  logic [INTERVAL_W-1:0] interval;
  logic                  enable;
  route_t                route;

  refresh_cfg u_cfg (
    .clk      (clk),
    .rst      (rst),
    .cfg      (cfg),
    .cfg_rdata(cfg_rdata),
    .interval (interval),
    .enable   (enable)
  );

  refresh_sched u_sched (
    .clk        (clk),
    .rst        (rst),
    .interval   (interval),
    .enable     (enable),
    .req        (req),
    .refr_active(refr_active),
    .refr_bank  (refr_bank)
  );

  row_map u_map (
    .clk        (clk),
    .rst        (rst),
    .req        (req),
    .refr_active(refr_active),
    .refr_bank  (refr_bank),
    .route      (route)
  );

  bank_store u_store (
    .clk   (clk),
    .req   (req),
    .route (route),
    .rdata (rdata),
    .rvalid(rvalid),
    .rst   (rst)
  );

endmodule

// File: bench/edram_chk.sv
module edram_chk
  import mem_geom_pkg::*;
  import ctrl_pkg::*;
(
  input logic     clk,
  input logic     rst,
  input mem_req_t req,
  input logic     rvalid,
  input logic     refr_active,
  input bank_t    refr_bank
);

  timeunit 1ns;
  timeprecision 100ps;

  logic rd_now;

  assign rd_now = (req.op == OP_READ);

  // a refresh takes its bank out of service for a single cycle only.
  refr_one_cycle: assert property (@(posedge clk) disable iff (rst)
    refr_active |=> !refr_active)
    else $error("refresh stayed active for two cycles in a row");

  refr_no_read: assert property (@(posedge clk) disable iff (rst)
    !(refr_active && rd_now && (addr_bank(req.vaddr) == refr_bank)))
    else $error("refresh coincided with a read to the refreshing bank");

  // rvalid is high exactly when a read was accepted READ_LATENCY edges earlier.
  rvalid_latency: assert property (@(posedge clk) disable iff (rst)
    rvalid == $past(rd_now, READ_LATENCY))
    else $error("rvalid did not follow a read by the fixed latency");

  rvalid_reset: assert property (@(posedge clk) rst |=> !rvalid)
    else $error("rvalid was high during reset");

endmodule

bind edram_top edram_chk u_chk (
  .clk        (clk),
  .rst        (rst),
  .req        (req),
  .rvalid     (rvalid),
  .refr_active(refr_active),
  .refr_bank  (refr_bank)
);

// File: bench/edram_tb.sv
module edram_tb
  import mem_geom_pkg::*;
  import ctrl_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int WAIT_LIMIT = 200;
  localparam int NUM_WORDS = 2 ** ADDR_W;

  logic                  clk;
  logic                  rst;
  mem_req_t              req;
  cfg_req_t              cfg;
  word_t                 rdata;
  logic                  rvalid;
  logic [CFG_DATA_W-1:0] cfg_rdata;
  logic                  refr_active;
  bank_t                 refr_bank;

  // shadow copy of the memory, plus the reads that still wait for data.
  word_t       shadow [NUM_WORDS];
  logic        written [NUM_WORDS];
  word_t       exp_q [$];
  int          due_q [$];
  logic [31:0] lfsr;
  int          cyc;
  int          errors;
  int          checks;
  string       test_name;

  edram_top uut (
    .clk        (clk),
    .rst        (rst),
    .req        (req),
    .cfg        (cfg),
    .rdata      (rdata),
    .rvalid     (rvalid),
    .cfg_rdata  (cfg_rdata),
    .refr_active(refr_active),
    .refr_bank  (refr_bank)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) begin
    cyc <= cyc + 1;
  end

  // fibonacci LFSR with taps 32, 22, 2 and 1, stepped once per bit handed out.
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      v = {v[30:0], fb};
    end
    return v;
  endfunction

  // the last word written to an address, or zero if it was never written.
  function automatic word_t expected_word(input vaddr_t a);
    if (written[a]) begin
      return shadow[a];
    end
    return '0;
  endfunction

  task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("CHECK FAILED %s: expected %0h, actual %0h", name, exp, act);
    end
  endtask

  task automatic issue(input op_e op, input vaddr_t a, input word_t d);
    mem_req_t r;
    r.op = op;
    r.vaddr = a;
    r.wdata = d;
    @(posedge clk);
    req <= r;
    if (op == OP_WRITE) begin
      shadow[a] = d;
      written[a] = 1'b1;
    end else if (op == OP_READ) begin
      exp_q.push_back(expected_word(a));
      // accepted at the next edge, data is seen two edges after that.
      due_q.push_back(cyc + 3);
    end
  endtask

  task automatic cfg_access(input logic wr, input cfg_reg_e reg_sel, input logic [15:0] d);
    cfg_req_t c;
    c.valid = 1'b1;
    c.write = wr;
    c.register = reg_sel;
    c.data = d;
    @(posedge clk);
    cfg <= c;
    @(posedge clk);
    cfg <= '0;
  endtask

  task automatic drain_reads();
    int n;
    n = 0;
    while (exp_q.size() != 0 && n < WAIT_LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (exp_q.size() != 0) begin
      errors++;
      $display("ERROR: %s: %0d reads never returned data", test_name, exp_q.size());
      exp_q.delete();
      due_q.delete();
    end
  endtask

  task automatic wait_refresh(output int at, output bank_t b);
    int n;
    n = 0;
    at = -1;
    b = '0;
    while (at < 0 && n < WAIT_LIMIT) begin
      @(negedge clk);
      n++;
      if (refr_active) begin
        at = cyc;
        b = refr_bank;
      end
    end
    if (at < 0) begin
      errors++;
      $display("ERROR: %s: no refresh seen within %0d cycles", test_name, WAIT_LIMIT);
    end
  endtask

  // read data and its arrival cycle are checked against the oldest outstanding read.
  always @(negedge clk) begin
    if (!rst && rvalid) begin
      if (exp_q.size() == 0) begin
        errors++;
        $display("ERROR: %s: rvalid rose with no read outstanding", test_name);
      end else begin
        compare({test_name, " read data"}, 32'(exp_q.pop_front()), 32'(rdata));
        compare({test_name, " read latency"}, 32'(due_q.pop_front()), 32'(cyc));
      end
    end
  end

  initial begin
    int     t_prev;
    int     t_now;
    bank_t  b;
    bank_t  rb;
    vaddr_t a;
    word_t  d;
    op_e    op;
    lfsr = 32'h8a28_4105;
    rst = 1'b1;
    req = '0;
    cfg = '0;
    cyc = 0;
    errors = 0;
    checks = 0;
    test_name = "reset";
    for (int i = 0; i < NUM_WORDS; i++) begin
      written[i] = 1'b0;
    end
    repeat (2) @(posedge clk);
    rst <= 1'b0;

    @(negedge clk);
    compare({test_name, " rvalid"}, 32'(0), 32'(rvalid));
    compare({test_name, " refr_active"}, 32'(0), 32'(refr_active));
    cfg_access(1'b0, REG_INTERVAL, 16'd0);
    @(negedge clk);
    compare({test_name, " interval"}, 32'(RESET_INTERVAL), 32'(cfg_rdata));
    cfg_access(1'b0, REG_ENABLE, 16'd0);
    @(negedge clk);
    compare({test_name, " enable"}, 32'(0), 32'(cfg_rdata));

    // with an idle port the refresh runs on its timer alone, starting at bank 0.
    test_name = "refresh period";
    cfg_access(1'b1, REG_INTERVAL, 16'd5);
    cfg_access(1'b1, REG_ENABLE, 16'd1);
    wait_refresh(t_prev, b);
    compare({test_name, " bank"}, 32'(0), 32'(b));
    for (int i = 1; i <= NUM_BANKS; i++) begin
      wait_refresh(t_now, b);
      compare({test_name, " bank"}, 32'(i % NUM_BANKS), 32'(b));
      compare({test_name, " spacing"}, 32'(5), 32'(t_now - t_prev));
      t_prev = t_now;
    end
    cfg_access(1'b1, REG_ENABLE, 16'd0);

    // the arrays power up unknown, so every word starts from a known zero.
    test_name = "no refresh";
    for (int i = 0; i < NUM_WORDS; i++) begin
      issue(OP_WRITE, vaddr_t'(i), '0);
    end
    for (int i = 0; i < 40; i++) begin
      a = vaddr_t'(rand_bits(ADDR_W));
      d = word_t'(rand_bits(DATA_W));
      issue(OP_WRITE, a, d);
    end
    for (int i = 0; i < 40; i++) begin
      a = vaddr_t'(rand_bits(ADDR_W));
      issue(OP_READ, a, '0);
    end
    issue(OP_NONE, '0, '0);
    drain_reads();

    // a short interval sends many writes to the cache row and forces writebacks.
    test_name = "refresh traffic";
    cfg_access(1'b1, REG_INTERVAL, 16'd3);
    cfg_access(1'b1, REG_ENABLE, 16'd1);
    for (int i = 0; i < 400; i++) begin
      op = rand_bits(1) ? OP_WRITE : OP_READ;
      a = vaddr_t'(rand_bits(ADDR_W));
      d = word_t'(rand_bits(DATA_W));
      issue(op, a, d);
    end
    issue(OP_NONE, '0, '0);
    drain_reads();

    test_name = "postponed refresh";
    rb = bank_t'(2);
    for (int i = 0; i < 24; i++) begin
      a = {row_t'(rand_bits(ROW_W)), rb};
      issue(OP_READ, a, '0);
      @(negedge clk);
      if (refr_active && refr_bank == rb) begin
        errors++;
        $display("ERROR: %s: bank %0d refreshed while it was read", test_name, rb);
      end
    end
    issue(OP_NONE, '0, '0);
    @(negedge clk);
    compare({test_name, " active"}, 32'(1), 32'(refr_active));
    compare({test_name, " bank"}, 32'(rb), 32'(refr_bank));
    drain_reads();
    cfg_access(1'b1, REG_ENABLE, 16'd0);

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// File: tb.f
hw/mem_geom_pkg.sv
hw/ctrl_pkg.sv
hw/refresh_cfg.sv
hw/refresh_sched.sv
hw/row_map.sv
hw/bank_store.sv
hw/edram_top.sv
bench/edram_chk.sv
bench/edram_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module edram_tb -f tb.f -o edram_sim

out=$(./obj_dir/edram_sim 2>&1) || true
echo "$out"

echo "$out" | grep -qx "Simulation finished: PASS"
